//--- qw_ctl_if.sv
// quadword counter control
// carries the frame length and beat strobes from the send FSM to the counter,
// and the last-beat flag and strobe back

`timescale 1ns/1ps
`include "rx_ibuf_defs.svh"

interface qw_ctl_if;

    logic                  load;       // pulse, latch len
    rx_ibuf_pkg::byte_len_t len;
    logic                  beat;       // pulse per accepted beat
    logic                  hold_last;  // freeze count
    logic                  is_last;    // next beat is the final one
    rx_ibuf_pkg::strb_t    last_strb;  // tstrb for the final beat

    modport fsm (
        output load, len, beat, hold_last,
        input  is_last, last_strb
    );

    modport cnt (
        input  load, len, beat, hold_last,
        output is_last, last_strb
    );

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rx_ibuf testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f rx_ibuf.f --top-module tb_rx_ibuf -o sim_rx_ibuf
./obj_dir/sim_rx_ibuf | tee sim.log
if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- rx_frame_writer.sv
// receive frame writer
// stores MAC words in the circular buffer behind a reserved header slot,
// writes the length header once the frame is complete and then publishes
// the committed producer pointer. frames that run out of room are dropped whole

`timescale 1ns/1ps
`include "rx_ibuf_defs.svh"

module rx_frame_writer (
    input  logic                   m_axis_aclk,
    input  logic                   m_axis_aresetp,
    input  logic                   in_valid_i,
    input  rx_ibuf_pkg::qword_t    in_data_i,
    input  logic                   in_last_i,
    input  logic [3:0]             in_bytes_i,        // valid bytes on last word
    input  rx_ibuf_pkg::buf_ptr_t  committed_cons_i,
    output logic                   wr_en_o,
    output rx_ibuf_pkg::buf_addr_t wr_addr_o,
    output rx_ibuf_pkg::qword_t    wr_data_o,
    output rx_ibuf_pkg::buf_ptr_t  committed_prod_o,
    output logic                   drop_o
);

    // one slot stays free so a new header never lands on the reader
    localparam int unsigned ROOM = (1 << `RX_IBUF_AW) - 1;

    rx_ibuf_pkg::buf_ptr_t  wptr_q;      // next data slot, header slot + 1 at start
    rx_ibuf_pkg::buf_ptr_t  used;        // words held between reader and wptr
    rx_ibuf_pkg::byte_len_t byte_cnt_q;  // running frame length
    rx_ibuf_pkg::byte_len_t byte_add;
    logic                   bad_q;       // frame already out of room
    logic                   hdr_pend_q;  // header write cycle
    logic                   fits;
    logic                   word_ok;
    logic                   bad_now;

    ////////////////////////////////////////
    // free space check
    ////////////////////////////////////////
    always_comb begin
        used     = wptr_q - committed_cons_i;
        fits     = (used < rx_ibuf_pkg::buf_ptr_t'(ROOM));
        word_ok  = in_valid_i & ~bad_q & fits;
        bad_now  = bad_q | ~fits;  // includes current word
        byte_add = in_last_i ? {12'h000, in_bytes_i} : 16'd8;
    end

    // write port, header wins in its cycle since the MAC idles then
    assign wr_en_o   = word_ok | hdr_pend_q;
    assign wr_addr_o = hdr_pend_q ? committed_prod_o[`RX_IBUF_AW-1:0]
                                  : wptr_q[`RX_IBUF_AW-1:0];
    assign wr_data_o = hdr_pend_q ? {16'h0000, byte_cnt_q, 32'h0000_0000}  // len in 47:32
                                  : in_data_i;

    ////////////////////////////////////////
    // pointers and frame status
    ////////////////////////////////////////
    always_ff @(posedge m_axis_aclk or posedge m_axis_aresetp) begin
        if (m_axis_aresetp) begin
            wptr_q           <= rx_ibuf_pkg::buf_ptr_t'(1);  // slot 0 reserved for header
            committed_prod_o <= '0;
            byte_cnt_q       <= '0;
            bad_q            <= 1'b0;
            hdr_pend_q       <= 1'b0;
            drop_o           <= 1'b0;
        end else begin
            drop_o     <= 1'b0;
            hdr_pend_q <= 1'b0;
            if (hdr_pend_q) begin
                // publish frame, reserve next header slot
                committed_prod_o <= wptr_q;
                wptr_q           <= wptr_q + 1'b1;
                byte_cnt_q       <= '0;
            end else if (in_valid_i) begin
                byte_cnt_q <= byte_cnt_q + byte_add;
                if (word_ok) begin
                    wptr_q <= wptr_q + 1'b1;
                end
                if (in_last_i) begin
                    bad_q <= 1'b0;
                    if (bad_now) begin
                        wptr_q     <= committed_prod_o + 1'b1;  // rewind, frame gone
                        byte_cnt_q <= '0;
                        drop_o     <= 1'b1;
                    end else begin
                        hdr_pend_q <= 1'b1;
                    end
                end else begin
                    bad_q <= bad_now;  // sticky until last
                end
            end
        end
    end

endmodule

//--- rx_ibuf.f
+incdir+.
rx_ibuf_pkg.sv
qw_ctl_if.sv
rx_frame_writer.sv
rx_ibuf_ram.sv
rx_qword_counter.sv
rx_send_fsm.sv
rx_ibuf_top.sv
tb_rx_ibuf.sv

//--- rx_ibuf_defs.svh
// rx_ibuf sizing
// buffer depth and stream widths shared by every block of the receive buffer

`ifndef RX_IBUF_DEFS_SVH
`define RX_IBUF_DEFS_SVH

////////////////////////////////////////
// buffer geometry
////////////////////////////////////////
`define RX_IBUF_AW 10   // word address bits, 1024 words of ram

////////////////////////////////////////
// stream widths
////////////////////////////////////////
`define RX_IBUF_DW 64   // one quadword per beat
`define RX_IBUF_UW 128  // tuser, only 15:0 carry the length

`endif

//--- rx_ibuf_pkg.sv
// rx_ibuf types
// vector types for addresses, pointers and lengths, plus the reader states

`include "rx_ibuf_defs.svh"

package rx_ibuf_pkg;

    typedef logic [`RX_IBUF_AW-1:0] buf_addr_t;  // ram word address
    typedef logic [`RX_IBUF_AW:0]   buf_ptr_t;   // extra msb tells full from empty
    typedef logic [`RX_IBUF_DW-1:0] qword_t;     // one data word
    typedef logic [15:0]            byte_len_t;  // frame length in bytes
    typedef logic [12:0]            qw_cnt_t;    // words per frame
    typedef logic [7:0]             strb_t;      // byte strobe

    // reader sequence
    typedef enum logic [2:0] {
        INIT,      // clear pointers
        WAIT_HDR,  // sit on header slot until a frame is committed
        DECODE,    // length into counter
        FIRST,     // first word out
        STREAM,    // one word per accepted beat
        STALL,     // tready low, next word parked
        LAST       // tlast waiting for tready
    } send_state_t;

endpackage

//--- rx_ibuf_ram.sv
// receive buffer ram
// simple dual-port block ram, one write port and one registered read port

`timescale 1ns/1ps
`include "rx_ibuf_defs.svh"

module rx_ibuf_ram (
    input  logic                   m_axis_aclk,
    input  logic                   wr_en_i,
    input  rx_ibuf_pkg::buf_addr_t wr_addr_i,
    input  rx_ibuf_pkg::qword_t    wr_data_i,
    input  rx_ibuf_pkg::buf_addr_t rd_addr_i,
    output rx_ibuf_pkg::qword_t    rd_data_o
);

    rx_ibuf_pkg::qword_t mem [0:(1 << `RX_IBUF_AW)-1];  // 1024 x 64

    always_ff @(posedge m_axis_aclk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // one cycle read latency, old data on same-address collision
    always_ff @(posedge m_axis_aclk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- rx_ibuf_top.sv
// rx_ibuf top level
// receive input buffer of a 10G port. MAC words go into a circular ram,
// complete frames leave as AXI4-Stream with the byte length on tuser

`timescale 1ns/1ps
`include "rx_ibuf_defs.svh"

module rx_ibuf_top (
    input  logic                   m_axis_aclk,
    input  logic                   m_axis_aresetp,
    // mac side
    input  logic                   in_valid_i,
    input  logic [`RX_IBUF_DW-1:0] in_data_i,
    input  logic                   in_last_i,
    input  logic [3:0]             in_bytes_i,
    // axis master
    output logic [`RX_IBUF_DW-1:0] m_axis_tdata_o,
    output logic [7:0]             m_axis_tstrb_o,
    output logic [`RX_IBUF_UW-1:0] m_axis_tuser_o,
    output logic                   m_axis_tvalid_o,
    output logic                   m_axis_tlast_o,
    input  logic                   m_axis_tready_i,
    output logic                   drop_o
);

    rx_ibuf_pkg::buf_ptr_t  committed_prod;
    rx_ibuf_pkg::buf_ptr_t  committed_cons;
    logic                   wr_en;
    rx_ibuf_pkg::buf_addr_t wr_addr;
    rx_ibuf_pkg::qword_t    wr_data;
    rx_ibuf_pkg::buf_addr_t rd_addr;
    rx_ibuf_pkg::qword_t    rd_data;

    qw_ctl_if qw_ctl ();

    rx_frame_writer i_rx_frame_writer (
        .m_axis_aclk      (m_axis_aclk),
        .m_axis_aresetp   (m_axis_aresetp),
        .in_valid_i       (in_valid_i),
        .in_data_i        (in_data_i),
        .in_last_i        (in_last_i),
        .in_bytes_i       (in_bytes_i),
        .committed_cons_i (committed_cons),
        .wr_en_o          (wr_en),
        .wr_addr_o        (wr_addr),
        .wr_data_o        (wr_data),
        .committed_prod_o (committed_prod),
        .drop_o           (drop_o)
    );

    rx_ibuf_ram i_rx_ibuf_ram (
        .m_axis_aclk (m_axis_aclk),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (rd_data)
    );

    rx_qword_counter i_rx_qword_counter (
        .m_axis_aclk    (m_axis_aclk),
        .m_axis_aresetp (m_axis_aresetp),
        .ctl            (qw_ctl)
    );

    rx_send_fsm i_rx_send_fsm (
        .m_axis_aclk      (m_axis_aclk),
        .m_axis_aresetp   (m_axis_aresetp),
        .committed_prod_i (committed_prod),
        .committed_cons_o (committed_cons),
        .rd_addr_o        (rd_addr),
        .rd_data_i        (rd_data),
        .ctl              (qw_ctl),
        .m_axis_tdata_o   (m_axis_tdata_o),
        .m_axis_tstrb_o   (m_axis_tstrb_o),
        .m_axis_tuser_o   (m_axis_tuser_o),
        .m_axis_tvalid_o  (m_axis_tvalid_o),
        .m_axis_tlast_o   (m_axis_tlast_o),
        .m_axis_tready_i  (m_axis_tready_i)
    );

endmodule

//--- rx_qword_counter.sv
// quadword counter
// decodes a byte length into words per frame and the last-beat strobe,
// then counts accepted beats and flags the final one

`timescale 1ns/1ps
`include "rx_ibuf_defs.svh"

module rx_qword_counter (
    input  logic  m_axis_aclk,
    input  logic  m_axis_aresetp,
    qw_ctl_if.cnt ctl
);

    rx_ibuf_pkg::qw_cnt_t qw_len_q;  // words in frame
    rx_ibuf_pkg::qw_cnt_t qw_snt_q;  // index of beat being loaded
    rx_ibuf_pkg::strb_t   strb_q;
    rx_ibuf_pkg::qw_cnt_t qw_len_d;
    rx_ibuf_pkg::strb_t   strb_d;

    always_comb begin
        qw_len_d = ctl.len[15:3] + {12'h000, |ctl.len[2:0]};  // round up
        strb_d   = (ctl.len[2:0] == 3'd0) ? 8'hff
                                          : (8'd1 << ctl.len[2:0]) - 8'd1;  // low bytes
    end

    always_ff @(posedge m_axis_aclk or posedge m_axis_aresetp) begin
        if (m_axis_aresetp) begin
            qw_len_q <= '0;
            qw_snt_q <= '0;
        end else if (ctl.load) begin
            qw_len_q <= qw_len_d;
            qw_snt_q <= 13'd2;  // beat 1 leaves before counting starts
        end else if (ctl.beat && !ctl.hold_last) begin
            qw_snt_q <= qw_snt_q + 1'b1;
        end
    end

    always_ff @(posedge m_axis_aclk) begin
        if (ctl.load) begin
            strb_q <= strb_d;
        end
    end

    assign ctl.is_last   = (qw_snt_q == qw_len_q);
    assign ctl.last_strb = strb_q;

endmodule

//--- rx_send_fsm.sv
// buffer to AXI4-Stream reader
// waits for committed frames, reads the length header, then streams the
// words out with a one-word skid register behind tdata for tready stalls

`timescale 1ns/1ps
`include "rx_ibuf_defs.svh"

module rx_send_fsm (
    input  logic                    m_axis_aclk,
    input  logic                    m_axis_aresetp,
    input  rx_ibuf_pkg::buf_ptr_t   committed_prod_i,
    output rx_ibuf_pkg::buf_ptr_t   committed_cons_o,
    output rx_ibuf_pkg::buf_addr_t  rd_addr_o,
    input  rx_ibuf_pkg::qword_t     rd_data_i,
    qw_ctl_if.fsm                   ctl,
    output rx_ibuf_pkg::qword_t     m_axis_tdata_o,
    output rx_ibuf_pkg::strb_t      m_axis_tstrb_o,
    output logic [`RX_IBUF_UW-1:0]  m_axis_tuser_o,
    output logic                    m_axis_tvalid_o,
    output logic                    m_axis_tlast_o,
    input  logic                    m_axis_tready_i
);

    rx_ibuf_pkg::send_state_t state_q;
    rx_ibuf_pkg::buf_ptr_t    rd_ptr_q;  // read address, also frees space
    rx_ibuf_pkg::buf_ptr_t    gap_q;     // committed words not yet read, one cycle old
    rx_ibuf_pkg::byte_len_t   len_q;
    rx_ibuf_pkg::qword_t      skid_q;    // word parked during a stall
    logic                     adv;       // tdata takes a new word

    assign committed_cons_o = rd_ptr_q;
    assign rd_addr_o        = rd_ptr_q[`RX_IBUF_AW-1:0];

    // counter control
    assign ctl.load      = (state_q == rx_ibuf_pkg::DECODE);
    assign ctl.len       = len_q;
    assign ctl.beat      = m_axis_tvalid_o & m_axis_tready_i;
    assign ctl.hold_last = (state_q == rx_ibuf_pkg::LAST);  // count stays on final beat

    assign adv = m_axis_tready_i &&
                 (state_q == rx_ibuf_pkg::STREAM || state_q == rx_ibuf_pkg::STALL);

    ////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////
    always_ff @(posedge m_axis_aclk or posedge m_axis_aresetp) begin
        if (m_axis_aresetp) begin
            state_q         <= rx_ibuf_pkg::INIT;
            rd_ptr_q        <= '0;
            gap_q           <= '0;
            m_axis_tvalid_o <= 1'b0;
            m_axis_tlast_o  <= 1'b0;
        end else begin
            // registered so the header read has settled when gap shows
            gap_q <= committed_prod_i - rd_ptr_q;
            case (state_q)
                rx_ibuf_pkg::INIT: begin
                    gap_q    <= '0;
                    rd_ptr_q <= '0;
                    state_q  <= rx_ibuf_pkg::WAIT_HDR;
                end
                rx_ibuf_pkg::WAIT_HDR: begin
                    if (gap_q != '0) begin
                        rd_ptr_q <= rd_ptr_q + 1'b1;  // past header
                        state_q  <= rx_ibuf_pkg::DECODE;
                    end
                end
                rx_ibuf_pkg::DECODE: begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;  // prefetch word 2
                    state_q  <= rx_ibuf_pkg::FIRST;
                end
                rx_ibuf_pkg::FIRST: begin
                    m_axis_tvalid_o <= 1'b1;
                    m_axis_tlast_o  <= 1'b0;
                    rd_ptr_q        <= rd_ptr_q + 1'b1;
                    state_q         <= rx_ibuf_pkg::STREAM;
                end
                rx_ibuf_pkg::STREAM, rx_ibuf_pkg::STALL: begin
                    if (m_axis_tready_i) begin
                        if (ctl.is_last) begin
                            m_axis_tlast_o <= 1'b1;
                            state_q        <= rx_ibuf_pkg::LAST;  // rd_ptr stays on next header
                        end else begin
                            rd_ptr_q <= rd_ptr_q + 1'b1;
                            state_q  <= rx_ibuf_pkg::STREAM;
                        end
                    end else begin
                        state_q <= rx_ibuf_pkg::STALL;
                    end
                end
                rx_ibuf_pkg::LAST: begin
                    if (m_axis_tready_i) begin
                        m_axis_tvalid_o <= 1'b0;  // at least one idle cycle between frames
                        m_axis_tlast_o  <= 1'b0;
                        if (gap_q != '0) begin
                            rd_ptr_q <= rd_ptr_q + 1'b1;  // header already in len_q
                            state_q  <= rx_ibuf_pkg::DECODE;
                        end else begin
                            state_q <= rx_ibuf_pkg::WAIT_HDR;
                        end
                    end
                end
                default: begin
                    state_q <= rx_ibuf_pkg::INIT;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // stream payload
    ////////////////////////////////////////
    always_ff @(posedge m_axis_aclk) begin
        // rd_data sits on the header slot in both states
        if (state_q == rx_ibuf_pkg::WAIT_HDR || state_q == rx_ibuf_pkg::LAST) begin
            len_q <= rd_data_i[47:32];
        end
        if (state_q == rx_ibuf_pkg::STREAM) begin
            skid_q <= rd_data_i;  // only used if tready drops
        end
        if (state_q == rx_ibuf_pkg::FIRST) begin
            m_axis_tdata_o <= rd_data_i;
            m_axis_tstrb_o <= 8'hff;
            m_axis_tuser_o <= {{(`RX_IBUF_UW-16){1'b0}}, len_q};
        end else if (adv) begin
            m_axis_tdata_o <= (state_q == rx_ibuf_pkg::STALL) ? skid_q : rd_data_i;
            m_axis_tstrb_o <= ctl.is_last ? ctl.last_strb : 8'hff;
        end
    end

endmodule

//--- tb_rx_ibuf.sv
// rx_ibuf testbench
// directed tests that drive MAC frames into the buffer and check the
// AXI4-Stream output beat by beat against a queue of expected words

`timescale 1ns/1ps
`include "rx_ibuf_defs.svh"

module tb_rx_ibuf;

    localparam int CYCLE_LIMIT = 20000;  // about four times the whole run
    localparam int ROOM_WORDS  = 1023;   // usable words, one slot kept free

    logic                   m_axis_aclk;
    logic                   m_axis_aresetp;
    logic                   in_valid;
    rx_ibuf_pkg::qword_t    in_data;
    logic                   in_last;
    logic [3:0]             in_bytes;
    rx_ibuf_pkg::qword_t    tdata;
    rx_ibuf_pkg::strb_t     tstrb;
    logic [`RX_IBUF_UW-1:0] tuser;
    logic                   tvalid;
    logic                   tlast;
    logic                   tready;
    logic                   drop;

    // frame model, one entry per expected beat
    rx_ibuf_pkg::qword_t    exp_data [$];
    rx_ibuf_pkg::strb_t     exp_strb [$];
    logic                   exp_last [$];
    rx_ibuf_pkg::byte_len_t exp_len  [$];

    logic [31:0] data_seed;
    logic [31:0] ready_seed;
    logic        rand_ready;   // tready from the generator
    string       cur_test;
    int          err_cnt, test_cnt, beat_cnt, drop_cnt, cycle_cnt;
    int          err_base, beat_base, drop_base;
    logic        stalled;      // tvalid high, tready low at last sample
    rx_ibuf_pkg::qword_t held_data;
    logic [25:0]         held_ctl;  // tvalid, tlast, tstrb, length

    rx_ibuf_top i_rx_ibuf_top (
        .m_axis_aclk     (m_axis_aclk),
        .m_axis_aresetp  (m_axis_aresetp),
        .in_valid_i      (in_valid),
        .in_data_i       (in_data),
        .in_last_i       (in_last),
        .in_bytes_i      (in_bytes),
        .m_axis_tdata_o  (tdata),
        .m_axis_tstrb_o  (tstrb),
        .m_axis_tuser_o  (tuser),
        .m_axis_tvalid_o (tvalid),
        .m_axis_tlast_o  (tlast),
        .m_axis_tready_i (tready),
        .drop_o          (drop)
    );

    initial begin
        m_axis_aclk = 1'b0;
        forever #5 m_axis_aclk = ~m_axis_aclk;  // 100 MHz
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("ERR %s %s expected %0h actual %0h", cur_test, what, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic send_frame(input int len, input bit keep);
        int nw, i, b;
        rx_ibuf_pkg::qword_t word;
        rx_ibuf_pkg::strb_t  strb;
        nw = (len + 7) / 8;  // words, rounded up
        for (i = 0; i < nw; i++) begin
            data_seed   = next_random(data_seed);
            word[63:32] = data_seed;
            data_seed   = next_random(data_seed);
            word[31:0]  = data_seed;
            for (b = 0; b < 8; b++) begin
                strb[b] = (i * 8 + b < len);  // byte inside the frame
            end
            @(posedge m_axis_aclk);
            #1;
            in_valid = 1'b1;
            in_data  = word;
            in_last  = (i == nw - 1);
            in_bytes = (i == nw - 1) ? 4'(len - 8 * (nw - 1)) : 4'd0;
            if (keep) begin
                exp_data.push_back(word);
                exp_strb.push_back(strb);
                exp_last.push_back(i == nw - 1);
                exp_len.push_back(16'(len));
            end
        end
        @(posedge m_axis_aclk);
        #1;
        in_valid = 1'b0;  // idle cycle for the header write
        in_last  = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_data.size() != 0) begin
            @(posedge m_axis_aclk);
        end
        repeat (8) @(posedge m_axis_aclk);  // room for stray beats
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        err_base  = err_cnt;
        beat_base = beat_cnt;
        drop_base = drop_cnt;
    endtask

    task automatic end_test(input int exp_beats, input int exp_drops);
        check_value("beat count", 128'(exp_beats), 128'(beat_cnt - beat_base));
        check_value("drop count", 128'(exp_drops), 128'(drop_cnt - drop_base));
        test_cnt++;
        if (err_cnt == err_base) begin
            $display("test %s passed", cur_test);
        end else begin
            $display("test %s failed, %0d mismatches", cur_test, err_cnt - err_base);
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic reset_test();
        start_test("reset");
        check_value("tvalid", 128'(0), 128'(tvalid));
        check_value("tlast", 128'(0), 128'(tlast));
        check_value("drop", 128'(0), 128'(drop));
        repeat (4) @(posedge m_axis_aclk);  // empty buffer stays quiet
        end_test(0, 0);
    endtask

    task automatic single_frame_test();
        start_test("single_frame");
        send_frame(64, 1'b1);
        wait_drain();
        end_test(8, 0);
    endtask

    task automatic last_strobe_test();
        int len, beats;
        start_test("last_strobe");
        beats = 0;
        for (len = 9; len <= 15; len++) begin
            send_frame(len, 1'b1);
            beats += (len + 7) / 8;
        end
        send_frame(61, 1'b1);
        beats += (61 + 7) / 8;
        wait_drain();
        end_test(beats, 0);
    endtask

    task automatic back_to_back_test();
        int lens [5];
        int i, beats;
        start_test("back_to_back");
        lens  = '{64, 9, 1500, 2000, 333};
        beats = 0;
        for (i = 0; i < 5; i++) begin
            send_frame(lens[i], 1'b1);
            beats += (lens[i] + 7) / 8;
        end
        wait_drain();
        end_test(beats, 0);
    endtask

    task automatic random_ready_test();
        int i, len, beats;
        start_test("random_ready");
        beats      = 0;
        rand_ready = 1'b1;
        for (i = 0; i < 20; i++) begin
            data_seed = next_random(data_seed);
            len       = 9 + int'(data_seed[23:16]) % 192;  // 20 frames fit without drops
            send_frame(len, 1'b1);
            beats += (len + 7) / 8;
        end
        wait_drain();
        @(posedge m_axis_aclk);
        #1;
        rand_ready = 1'b0;
        tready     = 1'b1;
        end_test(beats, 0);
    endtask

    task automatic buffer_full_test();
        int i, wc, used, kept, drops;
        start_test("buffer_full");
        @(posedge m_axis_aclk);
        #1;
        tready = 1'b0;
        wc     = (2000 + 7) / 8;
        used   = 0;
        kept   = 0;
        drops  = 0;
        for (i = 0; i < 6; i++) begin
            if (used + wc + 1 <= ROOM_WORDS) begin  // data plus header
                send_frame(2000, 1'b1);
                used += wc + 1;
                kept++;
            end else begin
                send_frame(2000, 1'b0);
                drops++;
            end
        end
        repeat (20) @(posedge m_axis_aclk);
        #1;
        tready = 1'b1;
        wait_drain();
        end_test(kept * wc, drops);
    endtask

    ////////////////////////////////////////
    // output monitor, sampled mid-cycle
    ////////////////////////////////////////
    always @(negedge m_axis_aclk) begin
        if (!m_axis_aresetp) begin
            if (drop) drop_cnt++;
            if (stalled) begin
                check_value("held tdata", held_data, tdata);
                check_value("held tvalid tlast tstrb tuser", held_ctl,
                            {tvalid, tlast, tstrb, tuser[15:0]});
            end
            if (tvalid && tready) begin
                beat_cnt++;
                if (exp_data.size() == 0) begin
                    err_cnt++;
                    $display("%s: a beat came out that no frame accounts for", cur_test);
                end else begin
                    check_value("tdata", exp_data.pop_front(), tdata);
                    check_value("tstrb", exp_strb.pop_front(), tstrb);
                    check_value("tlast", exp_last.pop_front(), tlast);
                    check_value("tuser", {112'd0, exp_len.pop_front()}, tuser);
                end
            end
            stalled   = tvalid && !tready;
            held_data = tdata;
            held_ctl  = {tvalid, tlast, tstrb, tuser[15:0]};
        end
    end

    // back-pressure pattern, about half the cycles
    always @(posedge m_axis_aclk) begin
        #1;
        if (rand_ready) begin
            ready_seed = next_random(ready_seed);
            tready     = ready_seed[16];
        end
    end

    always @(posedge m_axis_aclk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles in test %s", cycle_cnt, cur_test);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        m_axis_aresetp = 1'b1;
        in_valid       = 1'b0;
        in_data        = '0;
        in_last        = 1'b0;
        in_bytes       = 4'd0;
        tready         = 1'b1;
        rand_ready     = 1'b0;
        data_seed      = 32'h1aeb;
        ready_seed     = 32'h1aeb;
        stalled        = 1'b0;
        cur_test       = "reset";
        err_cnt        = 0;
        test_cnt       = 0;
        beat_cnt       = 0;
        drop_cnt       = 0;
        cycle_cnt      = 0;
        repeat (2) @(posedge m_axis_aclk);
        #1;
        m_axis_aresetp = 1'b0;
        reset_test();
        single_frame_test();
        last_strobe_test();
        back_to_back_test();
        random_ready_test();
        buffer_full_test();
        $display("tests %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
